//--- common/agnus_pkg.sv
// agnus dma package: bus types, register addresses and arbiter limits for the chip-bus arbiter
`default_nettype none

package agnus_pkg;

  // --------------------
  // bus widths
  // --------------------
  typedef logic [7:0]  reg_addr_t;   // register word address, 256 words
  typedef logic [19:0] chip_addr_t;  // chip memory word address

  // --------------------
  // register map
  // --------------------
  localparam reg_addr_t REG_DMACON  = 8'h4B;  // dma control write (byte 0x096)
  localparam reg_addr_t REG_DMACONR = 8'h01;  // dma control read (byte 0x002)
  localparam reg_addr_t REG_IDLE    = 8'hFF;  // nothing addressed on the register bus

  // blitter is held off once the cpu misses this many memory cycles
  localparam logic [1:0] BLS_CNT_MAX = 2'd3;

  // refresh takes the odd slots in this hpos window
  localparam logic [8:0] REFRESH_FIRST = 9'd1;
  localparam logic [8:0] REFRESH_LAST  = 9'd7;

  // --------------------
  // dmacon bit positions
  // --------------------
  localparam int DMACON_W   = 13;  // stored bits 12..0
  localparam int DMACON_SET = 15;  // set/clear select
  localparam int BLTPRI     = 10;  // blitter nasty
  localparam int DMAEN      = 9;   // master enable
  localparam int BPLEN      = 8;
  localparam int COPEN      = 7;
  localparam int BLTEN      = 6;
  localparam int SPREN      = 5;

  // cpu side of the register bus
  typedef struct packed {
    logic      aen;      // register bank select
    logic      rd;
    logic      hwr;
    logic      lwr;
    reg_addr_t address;
  } cpu_access_t;

  // dsk/aud/bpl say the slot is in use, spr/cop/blt are requests
  typedef struct packed {
    logic dsk;
    logic aud;
    logic bpl;
    logic spr;
    logic cop;
    logic blt;
  } dma_req_t;

  // payload one engine puts on the chip bus
  typedef struct packed {
    chip_addr_t address;
    reg_addr_t  reg_address;
    logic       we;        // memory write, only disk and blitter use it
  } chan_bus_t;

  // bus owner for the current slot
  typedef enum logic [2:0] {
    GRANT_CPU,
    GRANT_DSK,
    GRANT_REF,
    GRANT_AUD,
    GRANT_BPL,
    GRANT_SPR,
    GRANT_COP,
    GRANT_BLT
  } grant_t;

  // handshake levels back to the engines
  typedef struct packed {
    logic bpl_en;
    logic cop_ena;   // no bitplane fetch in this slot
    logic blt_ena;   // bus free for the blitter
    logic ack_spr;
    logic ack_cop;
    logic ack_blt;
  } chan_ctrl_t;

  // effective channel enables from dmacon
  typedef struct packed {
    logic bpl;
    logic spr;
    logic cop;
    logic blt;
    logic bltpri;
  } dma_en_t;

endpackage

`default_nettype wire

//--- design/dma_control.sv
// dma control: cpu register decode, dmacon set/clear register, readback and channel enables
`timescale 1ns/100ps
`default_nettype none

module dma_control import agnus_pkg::*; (
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic        clk7_en,      // bus clock enable
  input  wire cpu_access_t cpu,
  input  wire reg_addr_t   reg_address,  // granted register address
  input  wire logic [15:0] data_in,
  input  wire logic        blit_busy,
  input  wire logic        blit_zero,
  output reg_addr_t        cpu_reg_address,
  output logic      [15:0] dmaconr,
  output dma_en_t          dma_en
);

  logic [DMACON_W-1:0] dmacon;  // stored control bits 12..0
  logic                dmacon_wr;

  // --------------------
  // cpu decode
  // --------------------
  // idle address unless the cpu really accesses the register bank
  always_comb begin
    if (cpu.aen && (cpu.rd || cpu.hwr || cpu.lwr))
      cpu_reg_address = cpu.address;
    else
      cpu_reg_address = REG_IDLE;
  end

  // --------------------
  // control register
  // --------------------
  assign dmacon_wr = (reg_address == REG_DMACON);

  always_ff @(posedge clk) begin
    if (clk7_en) begin
      if (reset) begin
        dmacon <= '0;
      end else if (dmacon_wr) begin
        if (data_in[DMACON_SET])
          dmacon <= dmacon | data_in[DMACON_W-1:0];   // set ones
        else
          dmacon <= dmacon & ~data_in[DMACON_W-1:0];  // clear ones
      end
    end
  end

  // readback only drives the data bus when addressed, OR-ed at the output
  always_comb begin
    if (reg_address == REG_DMACONR)
      dmaconr = {1'b0, blit_busy, blit_zero, dmacon};
    else
      dmaconr = '0;
  end

  // --------------------
  // channel enables
  // --------------------
  assign dma_en.bpl    = dmacon[BPLEN] & dmacon[DMAEN];
  assign dma_en.spr    = dmacon[SPREN] & dmacon[DMAEN];
  assign dma_en.cop    = dmacon[COPEN] & dmacon[DMAEN];
  assign dma_en.blt    = dmacon[BLTEN] & dmacon[DMAEN];
  assign dma_en.bltpri = dmacon[BLTPRI];  // not gated by master enable

  // all channels come out of reset switched off
  a_en_off_after_reset: assert property (
    @(posedge clk) (reset && clk7_en) |=> (dma_en == '0)
  );

endmodule

`default_nettype wire

//--- arbiter/slot_arbiter.sv
// slot arbiter: refresh slot decode, blitter slowdown counter and fixed-priority bus grant
`timescale 1ns/100ps
`default_nettype none

module slot_arbiter import agnus_pkg::*; (
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire logic       clk7_en,
  input  wire logic [8:0] hpos,     // horizontal beam position
  input  wire logic       ddf,      // bitplane fetch window
  input  wire logic       cck,      // colour clock, high in odd slots
  input  wire logic       turbo,    // blitter may take extra slots
  input  wire logic       bls,      // cpu is waiting for the bus
  input  wire dma_req_t   dma_req,
  input  wire dma_en_t    dma_en,
  output grant_t          grant,
  output chan_ctrl_t      chan_ctrl
);

  logic [1:0] bls_cnt;    // memory cycles the cpu has missed the bus
  logic       bls_block;  // blitter held off for the cpu
  logic       bls_tick;   // counter qualifying edge
  logic       dma_ref;
  logic       dma_spr;
  logic       dma_cop;
  logic       dma_blt;
  logic       higher_busy;

  // --------------------
  // refresh slots
  // --------------------
  // odd slots only, inside the refresh window
  assign dma_ref = hpos[0] && (hpos >= REFRESH_FIRST) && (hpos <= REFRESH_LAST);

  // --------------------
  // eligibility
  // --------------------
  assign bls_block = (bls_cnt == BLS_CNT_MAX);

  // no sprite fetch while bitplanes own the fetch window
  assign dma_spr = dma_req.spr & dma_en.spr & ~(ddf & dma_en.bpl);
  assign dma_cop = dma_req.cop & dma_en.cop;
  assign dma_blt = dma_req.blt & dma_en.blt & ~bls_block;

  // first match wins: disk, refresh, audio, bitplane, sprite, copper, blitter
  always_comb begin
    if (dma_req.dsk)
      grant = GRANT_DSK;
    else if (dma_ref)
      grant = GRANT_REF;
    else if (dma_req.aud)
      grant = GRANT_AUD;
    else if (dma_req.bpl)
      grant = GRANT_BPL;
    else if (dma_spr)
      grant = GRANT_SPR;
    else if (dma_cop)
      grant = GRANT_COP;
    else if (dma_blt)
      grant = GRANT_BLT;
    else
      grant = GRANT_CPU;  // bus left to the cpu
  end

  // --------------------
  // engine handshake
  // --------------------
  assign higher_busy = dma_ref | dma_req.dsk | dma_req.aud | dma_spr | dma_req.bpl | dma_cop;

  assign chan_ctrl.bpl_en  = dma_en.bpl;
  assign chan_ctrl.cop_ena = ~dma_req.bpl;  // copper only loses odd slots to bitplanes
  assign chan_ctrl.blt_ena = dma_en.blt & ~higher_busy & ~bls_block;
  assign chan_ctrl.ack_spr = (grant == GRANT_SPR);
  assign chan_ctrl.ack_cop = (grant == GRANT_COP);
  assign chan_ctrl.ack_blt = (grant == GRANT_BLT);

  // --------------------
  // slowdown counter
  // --------------------
  assign bls_tick = ~cck | turbo;

  always_ff @(posedge clk) begin
    if (clk7_en) begin
      if (reset) begin
        bls_cnt <= '0;
      end else if (bls_tick) begin
        if (!bls || dma_en.bltpri)
          bls_cnt <= '0;                 // cpu got the bus, or blitter nasty
        else if (!bls_block)
          bls_cnt <= bls_cnt + 2'd1;     // saturate at max
      end
    end
  end

  // blitter must stay off the bus once the cpu has starved long enough
  a_no_blt_when_blocked: assert property (
    @(posedge clk) disable iff (reset) bls_block |-> !chan_ctrl.ack_blt
  );

endmodule

`default_nettype wire

//--- design/chip_bus_mux.sv
// chip bus mux: drives chip address, register address, bus flags and read data for the grant
`timescale 1ns/100ps
`default_nettype none

module chip_bus_mux import agnus_pkg::*; (
  input  wire grant_t      grant,
  input  wire chan_bus_t   dsk_bus,
  input  wire chan_bus_t   aud_bus,
  input  wire chan_bus_t   bpl_bus,
  input  wire chan_bus_t   spr_bus,
  input  wire chan_bus_t   cop_bus,
  input  wire chan_bus_t   blt_bus,
  input  wire reg_addr_t   cpu_reg_address,
  input  wire logic [15:0] dmaconr,
  input  wire logic [15:0] blt_data,
  output chip_addr_t       address_out,
  output reg_addr_t        reg_address,
  output logic             cpu_custom,  // cpu owns the custom chip bus
  output logic             dbr,         // agnus holds the data bus
  output logic             dbwe,        // dma memory write
  output logic      [15:0] data_out
);

  // --------------------
  // address select
  // --------------------
  always_comb begin
    address_out = '0;
    reg_address = REG_IDLE;
    dbwe        = 1'b0;
    unique case (grant)
      GRANT_DSK: begin
        address_out = dsk_bus.address;
        reg_address = dsk_bus.reg_address;
        dbwe        = dsk_bus.we;         // disk may write memory
      end
      GRANT_REF: ;                        // refresh: address 0, register bus idle
      GRANT_AUD: begin
        address_out = aud_bus.address;
        reg_address = aud_bus.reg_address;
      end
      GRANT_BPL: begin
        address_out = bpl_bus.address;
        reg_address = bpl_bus.reg_address;
      end
      GRANT_SPR: begin
        address_out = spr_bus.address;
        reg_address = spr_bus.reg_address;
      end
      GRANT_COP: begin
        address_out = cop_bus.address;
        reg_address = cop_bus.reg_address;
      end
      GRANT_BLT: begin
        address_out = blt_bus.address;
        reg_address = blt_bus.reg_address;
        dbwe        = blt_bus.we;         // blitter may write memory
      end
      GRANT_CPU: reg_address = cpu_reg_address;  // cpu register access passes through
    endcase
  end

  // --------------------
  // bus flags and data
  // --------------------
  assign dbr        = (grant != GRANT_CPU);
  assign cpu_custom = ~dbr;
  assign data_out   = dmaconr | blt_data;  // sources drive zero when idle

  // exactly one owner of the bus at any time
  always_comb begin
    a_one_owner: assert final (dbr != cpu_custom);
  end

endmodule

`default_nettype wire

//--- design/agnus_dma.sv
// agnus dma top: chip-bus slot arbiter with dma control register and bus multiplexer
`timescale 1ns/100ps
`default_nettype none

module agnus_dma import agnus_pkg::*; (
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic        clk7_en,
  input  wire cpu_access_t cpu,
  input  wire logic [15:0] data_in,
  input  wire logic        blit_busy,
  input  wire logic        blit_zero,
  input  wire logic [8:0]  hpos,
  input  wire logic        ddf,
  input  wire logic        cck,
  input  wire logic        turbo,
  input  wire logic        bls,
  input  wire dma_req_t    dma_req,
  input  wire chan_bus_t   dsk_bus,
  input  wire chan_bus_t   aud_bus,
  input  wire chan_bus_t   bpl_bus,
  input  wire chan_bus_t   spr_bus,
  input  wire chan_bus_t   cop_bus,
  input  wire chan_bus_t   blt_bus,
  input  wire logic [15:0] blt_data,
  output chip_addr_t       address_out,
  output reg_addr_t        reg_address,
  output logic             cpu_custom,
  output logic             dbr,
  output logic             dbwe,
  output logic      [15:0] data_out,
  output chan_ctrl_t       chan_ctrl
);

  reg_addr_t   cpu_reg_address;
  logic [15:0] dmaconr;
  dma_en_t     dma_en;
  grant_t      grant;

  // --------------------
  // input side
  // --------------------
  dma_control ctrl_i (
    .clk             (clk),
    .reset           (reset),
    .clk7_en         (clk7_en),
    .cpu             (cpu),
    .reg_address     (reg_address),      // granted address loops back
    .data_in         (data_in),
    .blit_busy       (blit_busy),
    .blit_zero       (blit_zero),
    .cpu_reg_address (cpu_reg_address),
    .dmaconr         (dmaconr),
    .dma_en          (dma_en)
  );

  // --------------------
  // arbitration
  // --------------------
  slot_arbiter arb_i (
    .clk       (clk),
    .reset     (reset),
    .clk7_en   (clk7_en),
    .hpos      (hpos),
    .ddf       (ddf),
    .cck       (cck),
    .turbo     (turbo),
    .bls       (bls),
    .dma_req   (dma_req),
    .dma_en    (dma_en),
    .grant     (grant),
    .chan_ctrl (chan_ctrl)
  );

  // --------------------
  // output side
  // --------------------
  chip_bus_mux mux_i (
    .grant           (grant),
    .dsk_bus         (dsk_bus),
    .aud_bus         (aud_bus),
    .bpl_bus         (bpl_bus),
    .spr_bus         (spr_bus),
    .cop_bus         (cop_bus),
    .blt_bus         (blt_bus),
    .cpu_reg_address (cpu_reg_address),
    .dmaconr         (dmaconr),
    .blt_data        (blt_data),
    .address_out     (address_out),
    .reg_address     (reg_address),
    .cpu_custom      (cpu_custom),
    .dbr             (dbr),
    .dbwe            (dbwe),
    .data_out        (data_out)
  );

endmodule

`default_nettype wire

//--- verif/agnus_dma_checker.sv
// dma arbiter checker: compares the dut outputs with expected values and keeps the error counts
`timescale 1ns/100ps
`default_nettype none

module agnus_dma_checker import agnus_pkg::*; (
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire chip_addr_t  address_out,
  input  wire reg_addr_t   reg_address,
  input  wire logic        cpu_custom,
  input  wire logic        dbr,
  input  wire logic        dbwe,
  input  wire logic [15:0] data_out,
  input  wire chan_ctrl_t  chan_ctrl,
  input  wire chip_addr_t  exp_address_out,
  input  wire reg_addr_t   exp_reg_address,
  input  wire logic        exp_cpu_custom,
  input  wire logic        exp_dbr,
  input  wire logic        exp_dbwe,
  input  wire logic [15:0] exp_data_out,
  input  wire chan_ctrl_t  exp_chan_ctrl,
  output int               error_count
);

  int checks;        // compares in the running test
  int test_errors;
  int total_checks;
  int tests;

  initial begin
    checks       = 0;
    test_errors  = 0;
    total_checks = 0;
    tests        = 0;
    error_count  = 0;
  end

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    total_checks++;
    if (got !== exp) begin
      $display("Mismatch %s exp %h got %h", name, exp, got);
      test_errors++;
      error_count++;
    end
  endtask

  // --------------------
  // sample mid-cycle
  // --------------------
  // inputs move 5 ns after the rising edge, outputs have settled by the falling edge
  always @(negedge clk) begin
    if (!reset) begin
      compare("address_out", exp_address_out, address_out);
      compare("reg_address", exp_reg_address, reg_address);
      compare("cpu_custom", exp_cpu_custom, cpu_custom);
      compare("dbr", exp_dbr, dbr);
      compare("dbwe", exp_dbwe, dbwe);
      compare("data_out", exp_data_out, data_out);
      compare("chan_ctrl", exp_chan_ctrl, chan_ctrl);
    end
  end

  // failures that are not a value compare, e.g. a wait that ran out
  task automatic fail_note(input string msg);
    $display("Error: %s", msg);
    test_errors++;
    error_count++;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %0d checks, %0d errors", tests, name, checks, test_errors);
    checks      = 0;
    test_errors = 0;
  endtask

  task automatic report();
    $display("tests %0d, checks %0d, errors %0d", tests, total_checks, error_count);
  endtask

endmodule

`default_nettype wire

//--- verif/agnus_dma_tb.sv
// agnus dma testbench: random stimulus, control register and slowdown models, reference outputs
`timescale 1ns/100ps
`default_nettype none

module agnus_dma_tb import agnus_pkg::*; ();

  typedef struct packed {
    chip_addr_t  address_out;
    reg_addr_t   reg_address;
    logic        cpu_custom;
    logic        dbr;
    logic        dbwe;
    logic [15:0] data_out;
    chan_ctrl_t  chan_ctrl;
  } expect_t;

  logic        clk, reset, clk7_en, blit_busy, blit_zero, ddf, cck, turbo, bls;
  cpu_access_t cpu;
  logic [15:0] data_in, blt_data, data_out;
  logic [8:0]  hpos;
  dma_req_t    dma_req;
  chan_bus_t   dsk_bus, aud_bus, bpl_bus, spr_bus, cop_bus, blt_bus;
  chip_addr_t  address_out;
  reg_addr_t   reg_address;
  logic        cpu_custom, dbr, dbwe;
  chan_ctrl_t  chan_ctrl;
  logic [DMACON_W-1:0] m_dmacon;  // control register model
  logic [1:0]  m_cnt;             // slowdown counter model
  expect_t     expected;
  int          error_count;
  int          seed;

  agnus_dma dut_i (.*);

  agnus_dma_checker chk_i (
    .clk, .reset, .address_out, .reg_address, .cpu_custom, .dbr, .dbwe, .data_out, .chan_ctrl,
    .exp_address_out (expected.address_out),
    .exp_reg_address (expected.reg_address),
    .exp_cpu_custom  (expected.cpu_custom),
    .exp_dbr         (expected.dbr),
    .exp_dbwe        (expected.dbwe),
    .exp_data_out    (expected.data_out),
    .exp_chan_ctrl   (expected.chan_ctrl),
    .error_count     (error_count)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // --------------------
  // reference
  // --------------------
  function automatic expect_t expected_outputs(
    input logic [DMACON_W-1:0] dmacon, input logic [1:0] cnt, input cpu_access_t c,
    input dma_req_t r, input logic [8:0] hp, input logic fetch, input logic busy,
    input logic zero, input logic [15:0] bdata, input chan_bus_t dsk, aud, bpl, spr, cop, blt);
    expect_t   e;
    chan_bus_t sel;
    logic      en_bpl, en_spr, en_cop, en_blt, refresh, blocked, spr_ok, cop_ok, blt_ok;
    en_bpl  = dmacon[BPLEN] && dmacon[DMAEN];
    en_spr  = dmacon[SPREN] && dmacon[DMAEN];
    en_cop  = dmacon[COPEN] && dmacon[DMAEN];
    en_blt  = dmacon[BLTEN] && dmacon[DMAEN];
    refresh = hp[0] && (hp >= REFRESH_FIRST) && (hp <= REFRESH_LAST);
    blocked = (cnt == BLS_CNT_MAX);
    spr_ok  = r.spr && en_spr && !(fetch && en_bpl);  // bitplanes own the window
    cop_ok  = r.cop && en_cop;
    blt_ok  = r.blt && en_blt && !blocked;
    e = '0;
    e.dbr = 1'b1;
    if (r.dsk) begin
      sel    = dsk;
      e.dbwe = dsk.we;
    end else if (refresh) begin
      sel = {20'd0, REG_IDLE, 1'b0};  // refresh puts nothing on the buses
    end else if (r.aud) begin
      sel = aud;
    end else if (r.bpl) begin
      sel = bpl;
    end else if (spr_ok) begin
      sel = spr;
      e.chan_ctrl.ack_spr = 1'b1;
    end else if (cop_ok) begin
      sel = cop;
      e.chan_ctrl.ack_cop = 1'b1;
    end else if (blt_ok) begin
      sel    = blt;
      e.dbwe = blt.we;
      e.chan_ctrl.ack_blt = 1'b1;
    end else begin
      e.dbr = 1'b0;  // cpu slot
      sel   = {20'd0, (c.aen && (c.rd || c.hwr || c.lwr)) ? c.address : REG_IDLE, 1'b0};
    end
    e.address_out = sel.address;
    e.reg_address = sel.reg_address;
    e.cpu_custom  = !e.dbr;
    e.data_out    = bdata | ((e.reg_address == REG_DMACONR) ? {1'b0, busy, zero, dmacon} : 16'h0);
    e.chan_ctrl.bpl_en  = en_bpl;
    e.chan_ctrl.cop_ena = !r.bpl;
    e.chan_ctrl.blt_ena = en_blt && !blocked
                          && !(r.dsk || refresh || r.aud || r.bpl || spr_ok || cop_ok);
    return e;
  endfunction

  assign expected = expected_outputs(m_dmacon, m_cnt, cpu, dma_req, hpos, ddf, blit_busy,
                                     blit_zero, blt_data, dsk_bus, aud_bus, bpl_bus, spr_bus,
                                     cop_bus, blt_bus);

  // state models follow the same enabled edges as the dut
  always @(posedge clk) begin
    if (clk7_en) begin
      if (reset) begin
        m_dmacon <= '0;
        m_cnt    <= '0;
      end else begin
        if (expected.reg_address == REG_DMACON)
          m_dmacon <= data_in[DMACON_SET] ? (m_dmacon | data_in[DMACON_W-1:0])
                                          : (m_dmacon & ~data_in[DMACON_W-1:0]);
        if (!cck || turbo) begin
          if (!bls || m_dmacon[BLTPRI])
            m_cnt <= '0;
          else if (m_cnt != BLS_CNT_MAX)
            m_cnt <= m_cnt + 2'd1;  // saturates
        end
      end
    end
  end

  // --------------------
  // stimulus helpers
  // --------------------
  function automatic reg_addr_t safe_reg(input reg_addr_t a);
    return (a == REG_DMACON) ? (a ^ 8'h01) : a;  // random traffic stays off the control register
  endfunction

  function automatic chan_bus_t random_bus();
    chan_bus_t b;
    b = 29'($urandom);
    b.reg_address = safe_reg(b.reg_address);
    return b;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic scramble_inputs();
    cpu = 12'($urandom);
    cpu.address = safe_reg(cpu.address);
    data_in  = 16'($urandom);
    blt_data = 16'($urandom);
    hpos     = 9'($urandom);
    dma_req  = 6'($urandom);
    {blit_busy, blit_zero, ddf, cck, turbo} = 5'($urandom);
    dsk_bus = random_bus();
    aud_bus = random_bus();
    bpl_bus = random_bus();
    spr_bus = random_bus();
    cop_bus = random_bus();
    blt_bus = random_bus();
  endtask

  // cpu write to dmacon in a free slot
  task automatic write_dmacon(input logic [15:0] value);
    dma_req = '0;
    hpos    = 9'd100;
    cpu     = {4'b1011, REG_DMACON};  // aen rd hwr lwr
    data_in = value;
    next_cycle();
    cpu = '0;
  endtask

  task automatic wait_ack_blt(input logic level, input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (chan_ctrl.ack_blt !== level && cycles < 10) begin
      @(negedge clk);
      cycles++;
    end
    if (chan_ctrl.ack_blt !== level)
      chk_i.fail_note({"timeout waiting for ", what});
    next_cycle();
  endtask

  // --------------------
  // test sequence
  // --------------------
  initial begin
    seed = 47063;
    seed = $urandom(seed);
    {reset, clk7_en, blit_busy, blit_zero, ddf, cck, turbo, bls} = 8'b1100_0000;
    cpu      = '0;
    data_in  = '0;
    blt_data = '0;
    hpos     = 9'd100;
    dma_req  = '0;
    {dsk_bus, aud_bus, bpl_bus, spr_bus, cop_bus, blt_bus} = '0;
    repeat (2) @(posedge clk);
    #5 reset = 1'b0;

    for (int i = 0; i < 16; i++) begin
      write_dmacon(16'h8000 | 16'($urandom));
      write_dmacon(16'($urandom) & 16'h7fff);
      cpu = {4'b1100, i[0] ? REG_DMACONR : 8'h10};  // read dmaconr or some other register
      {blit_busy, blit_zero} = 2'($urandom);
      next_cycle();
    end
    chk_i.end_test("dmacon set, clear and readback");

    write_dmacon(16'h7fff);
    write_dmacon(16'h83e0);  // dmaen bplen copen blten spren
    repeat (200) begin
      scramble_inputs();
      next_cycle();
    end
    chk_i.end_test("fixed priority");

    write_dmacon(16'h0200);  // master enable off
    repeat (100) begin
      scramble_inputs();
      next_cycle();
    end
    write_dmacon(16'h8200);
    repeat (100) begin
      scramble_inputs();
      ddf = 1'b1;
      dma_req.spr = 1'b1;
      next_cycle();
    end
    chk_i.end_test("channel gating");

    for (int i = 0; i < 80; i++) begin
      scramble_inputs();
      dma_req.dsk = 1'b0;
      hpos = 9'(i % 10);  // sweeps the refresh window
      next_cycle();
    end
    chk_i.end_test("refresh slots");

    {cck, turbo, bls} = 3'b001;
    dma_req = 6'b000001;  // blitter only
    hpos    = 9'd100;
    wait_ack_blt(1'b0, "bls to block the blitter");
    bls = 1'b0;
    wait_ack_blt(1'b1, "bls low to release the blitter");
    bls = 1'b1;
    wait_ack_blt(1'b0, "bls to block the blitter again");
    write_dmacon(16'h8400);  // blitter nasty
    dma_req = 6'b000001;
    wait_ack_blt(1'b1, "bltpri to release the blitter");
    write_dmacon(16'h0400);
    repeat (100) begin
      scramble_inputs();
      bls = 1'($urandom);
      next_cycle();
    end
    chk_i.end_test("blitter slowdown");

    repeat (150) begin
      scramble_inputs();
      if ($urandom_range(1) == 0)
        dma_req = '0;
      if ($urandom_range(3) == 0)
        cpu.address = REG_DMACONR;
      hpos = 9'd8 + 9'($urandom_range(400));
      next_cycle();
    end
    chk_i.end_test("cpu pass-through");

    chk_i.report();
    if (error_count == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
common/agnus_pkg.sv
design/dma_control.sv
arbiter/slot_arbiter.sv
design/chip_bus_mux.sv
design/agnus_dma.sv
verif/agnus_dma_checker.sv
verif/agnus_dma_tb.sv
